// ==== hw/duc_cfg_pkg.sv ====
// ---------------------------------------------------------------------
// Settings-bus register map and configuration types of the TX DUC.
// Shared by the settings block, the top level and the testbench.
// Offsets are relative to the BASE parameter of the top level.
// ---------------------------------------------------------------------
package duc_cfg_pkg;

   // Register offsets on the settings bus
   localparam logic [7:0] ADDR_PHASE_INC = 8'd0;
   localparam logic [7:0] ADDR_SCALE     = 8'd1;
   localparam logic [7:0] ADDR_RATE      = 8'd2;

   // Rate register layout
   typedef struct packed {
      logic [28:0] reserved;
      logic [2:0]  rate_log2;   // Interpolation is 2**rate_log2
   } rate_ctrl_t;

   // One settings data word, seen raw or as the rate register
   typedef union packed {
      logic [31:0] raw;
      rate_ctrl_t  rate;
   } set_word_u;

   // Live configuration handed to the datapath blocks
   typedef struct packed {
      logic [31:0]        phase_inc;   // NCO step per clock
      logic signed [17:0] scale;       // 4096 is unity gain
      logic [2:0]         rate_log2;
   } duc_cfg_t;

endpackage

// ==== hw/duc_dsp_pkg.sv ====
// ---------------------------------------------------------------------
// Sample widths and sample types of the TX DUC datapath.
// Baseband words come in at 16 bits, the CIC runs at 18 bits and the
// frontend takes 24 bits. The sine table is 16 bits, full scale 32767.
// ---------------------------------------------------------------------
package duc_dsp_pkg;

   localparam int BB_W   = 16;  // Baseband sample width
   localparam int IQ_W   = 18;  // Interpolated sample width
   localparam int FE_W   = 24;  // Frontend width
   localparam int TRIG_W = 16;  // Sine table amplitude

   // Baseband sample word, I in the upper half
   typedef struct packed {
      logic signed [BB_W-1:0] i;
      logic signed [BB_W-1:0] q;
   } bb_sample_t;

   // Interpolated sample, one per clock
   typedef struct packed {
      logic signed [IQ_W-1:0] i;
      logic signed [IQ_W-1:0] q;
   } iq_t;

   // Oscillator output pair
   typedef struct packed {
      logic signed [TRIG_W-1:0] cos;
      logic signed [TRIG_W-1:0] sin;
   } trig_t;

   // Frontend sample
   typedef struct packed {
      logic signed [FE_W-1:0] i;
      logic signed [FE_W-1:0] q;
   } fe_sample_t;

endpackage

// ==== hw/duc_settings.sv ====
// ---------------------------------------------------------------------
// Settings-bus decoder for the TX DUC.
// Holds phase increment, scale and rate. A write lands on the edge
// that samples set_stb_i; a rate write also pulses rate_change_o.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module duc_settings #(
   parameter int unsigned BASE = 0
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   set_stb_i,
   input  logic [7:0]             set_addr_i,
   input  logic [31:0]            set_data_i,
   output duc_cfg_pkg::duc_cfg_t  cfg_o,
   output logic                   rate_change_o
);
   import duc_cfg_pkg::*;

   localparam logic signed [17:0] SCALE_UNITY = 18'sd4096;

   set_word_u set_word;
   logic      hit_phase;
   logic      hit_scale;
   logic      hit_rate;

   assign set_word = set_data_i;

   // Address match against the block base
   assign hit_phase = set_stb_i && (set_addr_i == 8'(BASE + ADDR_PHASE_INC));
   assign hit_scale = set_stb_i && (set_addr_i == 8'(BASE + ADDR_SCALE));
   assign hit_rate  = set_stb_i && (set_addr_i == 8'(BASE + ADDR_RATE));

   always_ff @(posedge clk) begin
      if (rst) begin
         cfg_o.phase_inc <= '0;
         cfg_o.scale     <= SCALE_UNITY;
         cfg_o.rate_log2 <= '0;
         rate_change_o   <= 1'b0;
      end else begin
         if (hit_phase) begin
            cfg_o.phase_inc <= set_word.raw;
         end
         if (hit_scale) begin
            cfg_o.scale <= signed'(set_word.raw[17:0]);  // Low 18 bits only
         end
         if (hit_rate) begin
            cfg_o.rate_log2 <= set_word.rate.rate_log2;
         end
         // Pulse lines up with the new rate value
         rate_change_o <= hit_rate;
      end
   end

endmodule

// ==== hw/duc_interp.sv ====
// ---------------------------------------------------------------------
// Sample strober and CIC interpolator for I and Q.
// Pulls one baseband sample every 2**rate_log2 clocks and delivers
// one 18-bit sample per clock, with the CIC gain shifted out.
// Latency from a taken sample to interp_o is CIC_STAGES + 1 clocks.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module duc_interp #(
   parameter int CIC_STAGES = 4
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run_i,
   input  logic                     rate_change_i,
   input  logic [2:0]               rate_log2_i,
   input  duc_dsp_pkg::bb_sample_t  sample_i,
   output logic                     strobe_o,
   output duc_dsp_pkg::iq_t         interp_o
);
   import duc_dsp_pkg::*;

   localparam int MAX_LOG2 = 7;
   // Growth is (N-1)*log2(R) at the output, plus some headroom
   localparam int ACC_W = IQ_W + CIC_STAGES + (CIC_STAGES - 1) * MAX_LOG2;

   logic [MAX_LOG2-1:0]     cnt;
   logic [MAX_LOG2-1:0]     cnt_max;
   logic                    clear;
   logic [5:0]              shamt;
   logic signed [ACC_W-1:0] x_in    [2];
   logic signed [ACC_W-1:0] comb_s  [2][CIC_STAGES+1];
   logic signed [ACC_W-1:0] comb_d  [2][CIC_STAGES];
   logic signed [ACC_W-1:0] stuffed [2];
   logic signed [ACC_W-1:0] integ   [2][CIC_STAGES];
   logic signed [ACC_W-1:0] norm    [2];

   assign clear   = rst || !run_i || rate_change_i;
   assign cnt_max = ~({MAX_LOG2{1'b1}} << rate_log2_i);  // 2**rate_log2 - 1
   assign shamt   = 6'((CIC_STAGES - 1) * rate_log2_i);

   // Strobe counter, first pulse one clock after run rises
   always_ff @(posedge clk) begin
      if (clear) begin
         cnt      <= '0;
         strobe_o <= 1'b0;
      end else begin
         strobe_o <= (cnt == '0);
         cnt      <= (cnt == cnt_max) ? '0 : cnt + 1'b1;
      end
   end

   // Comb section on the held sample, then zero stuffing
   always_comb begin
      x_in[0] = {{(ACC_W-IQ_W){sample_i.i[BB_W-1]}}, sample_i.i, {(IQ_W-BB_W){1'b0}}};
      x_in[1] = {{(ACC_W-IQ_W){sample_i.q[BB_W-1]}}, sample_i.q, {(IQ_W-BB_W){1'b0}}};
      for (int ch = 0; ch < 2; ch++) begin
         comb_s[ch][0] = x_in[ch];
         for (int k = 0; k < CIC_STAGES; k++) begin
            comb_s[ch][k+1] = comb_s[ch][k] - comb_d[ch][k];
         end
         stuffed[ch] = strobe_o ? comb_s[ch][CIC_STAGES] : '0;
         // Gain removal, R**(N-1) is an exact shift
         norm[ch] = integ[ch][CIC_STAGES-1] >>> shamt;
      end
   end

   always_ff @(posedge clk) begin
      if (clear) begin
         for (int ch = 0; ch < 2; ch++) begin
            for (int k = 0; k < CIC_STAGES; k++) begin
               comb_d[ch][k] <= '0;
               integ[ch][k]  <= '0;
            end
         end
         interp_o <= '0;
      end else begin
         for (int ch = 0; ch < 2; ch++) begin
            if (strobe_o) begin
               for (int k = 0; k < CIC_STAGES; k++) begin
                  comb_d[ch][k] <= comb_s[ch][k];  // Comb delay, one per sample
               end
            end
            integ[ch][0] <= integ[ch][0] + stuffed[ch];
            for (int k = 1; k < CIC_STAGES; k++) begin
               integ[ch][k] <= integ[ch][k] + integ[ch][k-1];
            end
         end
         // Output register, the stage that lines up with the sine table
         interp_o.i <= norm[0][IQ_W-1:0];
         interp_o.q <= norm[1][IQ_W-1:0];
      end
   end

endmodule

// ==== hw/duc_nco.sv ====
// ---------------------------------------------------------------------
// Numerically controlled oscillator for the TX DUC.
// A 32-bit phase accumulator drives a quarter-wave sine table.
// trig_o follows its phase by one clock, two after the accumulate.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module duc_nco (
   input  logic                clk,
   input  logic                rst,
   input  logic                run_i,
   input  logic [31:0]         phase_inc_i,
   output duc_dsp_pkg::trig_t  trig_o
);
   import duc_dsp_pkg::*;

   typedef logic [TRIG_W-1:0] rom_t [256];

   // Entry 0 is exactly 0, entry 255 exactly full scale
   function automatic rom_t make_rom();
      rom_t rom;
      real  ang;
      for (int n = 0; n < 256; n++) begin
         ang    = 1.5707963267948966 * n / 255.0;
         rom[n] = TRIG_W'($rtoi(32767.0 * $sin(ang) + 0.5));
      end
      return rom;
   endfunction

   localparam rom_t SINE_ROM = make_rom();

   logic [31:0]              phase;
   logic [1:0]               quad;
   logic [7:0]               idx;
   logic signed [TRIG_W-1:0] t_fwd;
   logic signed [TRIG_W-1:0] t_rev;
   trig_t                    trig_next;

   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         phase <= '0;
      end else begin
         phase <= phase + phase_inc_i;
      end
   end

   always_comb begin
      quad  = phase[31:30];
      idx   = phase[29:22];
      t_fwd = signed'(SINE_ROM[idx]);
      t_rev = signed'(SINE_ROM[8'd255 - idx]);  // Mirrored, gives the cosine
      case (quad)
         2'd0: begin
            trig_next.cos = t_rev;
            trig_next.sin = t_fwd;
         end
         2'd1: begin
            trig_next.cos = -t_fwd;
            trig_next.sin = t_rev;
         end
         2'd2: begin
            trig_next.cos = -t_rev;
            trig_next.sin = -t_fwd;
         end
         default: begin
            trig_next.cos = t_fwd;
            trig_next.sin = -t_rev;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      trig_o <= trig_next;  // Table stage
   end

endmodule

// ==== hw/duc_mixer.sv ====
// ---------------------------------------------------------------------
// Complex mixer for the TX DUC.
// Rotates the interpolated I/Q by the NCO pair, applies the scale
// factor and saturates to the 24-bit frontend. Three clocks deep.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module duc_mixer (
   input  logic                     clk,
   input  logic                     rst,
   input  duc_dsp_pkg::iq_t         interp_i,
   input  duc_dsp_pkg::trig_t       trig_i,
   input  logic signed [17:0]       scale_i,
   output duc_dsp_pkg::fe_sample_t  fe_o
);
   import duc_dsp_pkg::*;

   localparam int PROD_W = IQ_W + TRIG_W;   // Full product
   localparam int PSH_W  = PROD_W - 15;     // After dropping the table scale
   localparam int ROT_W  = PSH_W + 1;
   localparam int SCL_W  = ROT_W + 18;
   localparam logic signed [SCL_W-1:0] FE_MAX = SCL_W'(2 ** (FE_W - 1) - 1);
   localparam logic signed [SCL_W-1:0] FE_MIN = SCL_W'(-(2 ** (FE_W - 1)));

   logic signed [PSH_W-1:0] p_ic, p_qs, p_is, p_qc;
   logic signed [ROT_W-1:0] rot_i, rot_q;

   // Drop the 4096 unity of the scale and clip to 24 bits
   function automatic logic signed [FE_W-1:0] sat_fe(input logic signed [SCL_W-1:0] v);
      logic signed [SCL_W-1:0] sh;
      sh = v >>> 12;
      if (sh > FE_MAX) begin
         return FE_MAX[FE_W-1:0];
      end else if (sh < FE_MIN) begin
         return FE_MIN[FE_W-1:0];
      end
      return sh[FE_W-1:0];
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         p_ic  <= '0;
         p_qs  <= '0;
         p_is  <= '0;
         p_qc  <= '0;
         rot_i <= '0;
         rot_q <= '0;
         fe_o  <= '0;
      end else begin
         // Products
         p_ic <= PSH_W'((PROD_W'(interp_i.i) * PROD_W'(trig_i.cos)) >>> 15);
         p_qs <= PSH_W'((PROD_W'(interp_i.q) * PROD_W'(trig_i.sin)) >>> 15);
         p_is <= PSH_W'((PROD_W'(interp_i.i) * PROD_W'(trig_i.sin)) >>> 15);
         p_qc <= PSH_W'((PROD_W'(interp_i.q) * PROD_W'(trig_i.cos)) >>> 15);
         // Rotation
         rot_i <= ROT_W'(p_ic) - ROT_W'(p_qs);
         rot_q <= ROT_W'(p_is) + ROT_W'(p_qc);
         // Scale and saturate
         fe_o.i <= sat_fe(SCL_W'(rot_i) * SCL_W'(scale_i));
         fe_o.q <= sat_fe(SCL_W'(rot_q) * SCL_W'(scale_i));
      end
   end

endmodule

// ==== hw/duc_chain.sv ====
// ---------------------------------------------------------------------
// Top level of the TX digital up-conversion chain.
// Settings bus in, baseband samples pulled by strobe_o, 24-bit I/Q
// out to the frontend. BASE places the three registers on the bus.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module duc_chain #(
   parameter int unsigned BASE       = 0,
   parameter int          CIC_STAGES = 4
) (
   input  logic                     clk,
   input  logic                     rst,
   // Settings bus
   input  logic                     set_stb_i,
   input  logic [7:0]               set_addr_i,
   input  logic [31:0]              set_data_i,
   // TX control
   input  duc_dsp_pkg::bb_sample_t  sample_i,
   input  logic                     run_i,
   output logic                     strobe_o,
   // Frontend
   output duc_dsp_pkg::fe_sample_t  tx_fe_o
);
   import duc_cfg_pkg::*;
   import duc_dsp_pkg::*;

   duc_cfg_t cfg;
   logic     rate_change;
   iq_t      interp;
   trig_t    trig;

   duc_settings #(.BASE(BASE)) i_settings (
      .clk           (clk),
      .rst           (rst),
      .set_stb_i     (set_stb_i),
      .set_addr_i    (set_addr_i),
      .set_data_i    (set_data_i),
      .cfg_o         (cfg),
      .rate_change_o (rate_change)
   );

   duc_interp #(.CIC_STAGES(CIC_STAGES)) i_interp (
      .clk           (clk),
      .rst           (rst),
      .run_i         (run_i),
      .rate_change_i (rate_change),
      .rate_log2_i   (cfg.rate_log2),
      .sample_i      (sample_i),
      .strobe_o      (strobe_o),
      .interp_o      (interp)
   );

   duc_nco i_nco (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .phase_inc_i (cfg.phase_inc),
      .trig_o      (trig)
   );

   duc_mixer i_mixer (
      .clk      (clk),
      .rst      (rst),
      .interp_i (interp),
      .trig_i   (trig),
      .scale_i  (cfg.scale),
      .fe_o     (tx_fe_o)
   );

endmodule

// ==== testbench/tb_clk_gen.sv ====
// ---------------------------------------------------------------------
// Clock and reset source for the DUC testbench.
// rst_o is high for RST_CYCLES rising edges, then drops on a
// falling edge so the DUT leaves reset cleanly.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 2
) (
   output logic clk_o,
   output logic rst_o
);
   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

// ==== testbench/tb_duc_chain.sv ====
// ---------------------------------------------------------------------
// Testbench for the TX DUC chain.
// Programs the settings bus, answers strobe_o with DC samples and
// compares tx_fe_o against a reference model of the mixer rule.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module tb_duc_chain;
   import duc_cfg_pkg::*;
   import duc_dsp_pkg::*;

   localparam int unsigned BASE       = 8'h40;
   localparam int          CIC_STAGES = 4;

   logic        clk;
   logic        rst;
   logic        set_stb;
   logic [7:0]  set_addr;
   logic [31:0] set_data;
   logic        run;
   logic        strobe;
   bb_sample_t  sample;
   fe_sample_t  tx_fe;
   bb_sample_t  cur_sample;    // DC value of the current test
   logic        check_req;
   logic        check_done;
   int          check_mode;    // 0 steady DC, 1 quarter-turn
   string       check_name;
   longint      check_scale;
   int          cyc;

   tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) i_clk_gen (.clk_o(clk), .rst_o(rst));

   duc_chain #(.BASE(BASE), .CIC_STAGES(CIC_STAGES)) i_dut (
      .clk        (clk),
      .rst        (rst),
      .set_stb_i  (set_stb),
      .set_addr_i (set_addr),
      .set_data_i (set_data),
      .sample_i   (sample),
      .run_i      (run),
      .strobe_o   (strobe),
      .tx_fe_o    (tx_fe)
   );

   // Expected frontend word for a DC input at one exact quadrant
   function automatic fe_sample_t mix_ref(longint bi, longint bq, int quad, longint scale);
      longint     c;
      longint     s;
      longint     rot [2];
      longint     v;
      fe_sample_t res;
      c = (quad == 0) ? 32767 : (quad == 2) ? -32767 : 0;
      s = (quad == 1) ? 32767 : (quad == 3) ? -32767 : 0;
      // CIC passes DC as the input times 4
      rot[0] = ((bi * 4 * c) >>> 15) - ((bq * 4 * s) >>> 15);
      rot[1] = ((bi * 4 * s) >>> 15) + ((bq * 4 * c) >>> 15);
      for (int k = 0; k < 2; k++) begin
         v = (rot[k] * scale) >>> 12;
         v = (v > 8388607) ? 8388607 : (v < -8388608) ? -8388608 : v;
         rot[k] = v;
      end
      res.i = 24'(rot[0]);
      res.q = 24'(rot[1]);
      return res;
   endfunction

   task automatic check_val(input string name, input longint expected, input longint actual);
      if (expected != actual) begin
         $display("error %s: expected %0d, actual %0d", name, expected, actual);
         $display("sim failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("timeout: %s did not happen in time", what);
      $display("sim failed");
      $fatal(1, "wait ran out of cycles");
   endtask

   task automatic next_strobe();
      for (int n = 0; n < 64; n++) begin
         @(negedge clk);
         if (strobe) begin
            return;
         end
      end
      fail_timeout("a strobe_o pulse");
   endtask

   // Output unchanged for a number of clocks
   task automatic hold_steady(input int need);
      fe_sample_t last;
      int         same;
      last = tx_fe;
      same = 0;
      for (int n = 0; n < 64; n++) begin
         @(negedge clk);
         same = (tx_fe == last) ? same + 1 : 0;
         last = tx_fe;
         if (same >= need) begin
            return;
         end
      end
      fail_timeout("a steady tx_fe_o");
   endtask

   task automatic reach_value(input fe_sample_t target, input string what);
      for (int n = 0; n < 64; n++) begin
         @(negedge clk);
         if (tx_fe == target) begin
            return;
         end
      end
      fail_timeout(what);
   endtask

   task automatic write_reg(input logic [7:0] offs, input logic [31:0] data);
      @(negedge clk);
      set_stb  = 1'b1;
      set_addr = 8'(BASE) + offs;
      set_data = data;
      @(negedge clk);
      set_stb  = 1'b0;
   endtask

   // Stop the chain and load a fresh configuration
   task automatic setup_chain(input logic [31:0] phase_inc, input longint scale, input int rate);
      @(negedge clk);
      run = 1'b0;
      repeat (4) @(negedge clk);   // Mixer pipeline drains
      write_reg(ADDR_PHASE_INC, phase_inc);
      write_reg(ADDR_SCALE, 32'(scale));
      write_reg(ADDR_RATE, 32'(rate));
   endtask

   task automatic run_check(input int mode, input string name, input longint scale);
      cur_sample.i = 16'($urandom);
      cur_sample.q = 16'($urandom);
      check_mode   = mode;
      check_name   = name;
      check_scale  = scale;
      @(negedge clk);
      run        = 1'b1;
      check_done = 1'b0;
      check_req  = 1'b1;
      for (int n = 0; n < 1024; n++) begin
         @(negedge clk);
         if (check_done) begin
            return;
         end
      end
      fail_timeout({"the ", name, " check"});
   endtask

   always @(posedge clk) cyc <= cyc + 1;

   // Feeder answers each strobe with the current sample
   always @(negedge clk) begin
      if (strobe) begin
         sample = cur_sample;
      end
   end

   initial begin : compare
      fe_sample_t exp_fe;
      forever begin
         @(negedge clk);
         if (check_req) begin
            check_req = 1'b0;
            repeat (CIC_STAGES + 2) next_strobe();  // Comb history filled
            exp_fe = mix_ref(cur_sample.i, cur_sample.q, 0, check_scale);
            if (check_mode == 0) begin
               hold_steady(8);
               check_val({check_name, ".i"}, exp_fe.i, tx_fe.i);
               check_val({check_name, ".q"}, exp_fe.q, tx_fe.q);
            end else begin
               repeat (CIC_STAGES + 4) @(negedge clk);  // CIC and mixer latency
               reach_value(exp_fe, "the first quarter-turn value");
               for (int k = 1; k < 4; k++) begin
                  @(negedge clk);
                  exp_fe = mix_ref(cur_sample.i, cur_sample.q, k, check_scale);
                  check_val($sformatf("%s.quad%0d.i", check_name, k), exp_fe.i, tx_fe.i);
                  check_val($sformatf("%s.quad%0d.q", check_name, k), exp_fe.q, tx_fe.q);
               end
            end
            check_done = 1'b1;
         end
      end
   end

   initial begin : main
      int     cnt;
      int     exp_cnt;
      int     t0;
      int     rates [3];
      longint scale;
      set_stb    = 1'b0;
      set_addr   = '0;
      set_data   = '0;
      sample     = '0;
      run        = 1'b0;
      cur_sample = '0;
      check_req  = 1'b0;
      check_done = 1'b0;
      rates      = '{0, 3, 7};
      void'($urandom(32'hc3cd_5e24));
      for (int n = 0; n < 16 && rst; n++) begin
         @(negedge clk);
      end
      if (rst) begin
         fail_timeout("release of reset");
      end
      // Nothing moves while run_i is low
      repeat (50) begin
         @(negedge clk);
         check_val("idle.strobe", 0, strobe);
         check_val("idle.fe", 0, tx_fe);
      end
      foreach (rates[r]) begin
         setup_chain(32'd0, 4096, rates[r]);
         @(negedge clk);
         run = 1'b1;
         cnt = 0;
         repeat (1024) begin
            @(negedge clk);
            cnt += strobe;
         end
         exp_cnt = 1024 >> rates[r];
         // One pulse of slack at the window edges
         cnt = (cnt >= exp_cnt - 1 && cnt <= exp_cnt + 1) ? exp_cnt : cnt;
         check_val($sformatf("strobe_rate%0d", rates[r]), exp_cnt, cnt);
      end
      setup_chain(32'd0, 4096, 2);
      run_check(0, "dc_rate2", 4096);
      setup_chain(32'd0, 4096, 5);
      run_check(0, "dc_rate5", 4096);
      setup_chain(32'h4000_0000, 4096, 1);
      run_check(1, "quarter_turn", 4096);
      scale = longint'(signed'(18'($urandom)));
      setup_chain(32'd0, scale, 3);
      run_check(0, "scale_rand", scale);
      setup_chain(32'd0, 131071, 0);
      run_check(0, "scale_max", 131071);
      // Rate change while running, then stop
      write_reg(ADDR_RATE, 32'd4);
      next_strobe();
      t0 = cyc;
      next_strobe();
      check_val("rate_change.period", 16, cyc - t0);
      run = 1'b0;
      reach_value('0, "return of tx_fe_o to zero after run_i dropped");
      $display("sim passed");
      $finish;
   end

endmodule

// ==== project.f ====
hw/duc_cfg_pkg.sv
hw/duc_dsp_pkg.sv
hw/duc_settings.sv
hw/duc_interp.sv
hw/duc_nco.sv
hw/duc_mixer.sv
hw/duc_chain.sv
testbench/tb_clk_gen.sv
testbench/tb_duc_chain.sv

// ==== Bender.yml ====
package:
  name: duc_chain

sources:
  - files:
      - hw/duc_cfg_pkg.sv
      - hw/duc_dsp_pkg.sv
      - hw/duc_settings.sv
      - hw/duc_interp.sv
      - hw/duc_nco.sv
      - hw/duc_mixer.sv
      - hw/duc_chain.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_duc_chain.sv
